// ==== Bender.yml ====
package:
  name: xbar_router

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/xbar_pkg.sv
      - verilog/xbar_req_if.sv
      - verilog/xbar_input_queue.sv
      - verilog/xbar_arbiter.sv
      - verilog/xbar_output_mux.sv
      - verilog/xbar_router.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_xbar_router.sv

// ==== project.f ====
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_req_if.sv
verilog/xbar_input_queue.sv
verilog/xbar_arbiter.sv
verilog/xbar_output_mux.sv
verilog/xbar_router.sv
tb/tb_clk_gen.sv
tb/tb_xbar_router.sv

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // low for the first cycles and released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== tb/tb_xbar_router.sv ====
// Router crossbar testbench
`timescale 1ns/1ps
`include "xbar_settings.svh"

module tb_xbar_router
  import xbar_pkg::*;
  ();

  localparam int IN_ELS     = `XBAR_IN_ELS;
  localparam int OUT_ELS    = `XBAR_OUT_ELS;
  localparam int DEPTH      = `XBAR_FIFO_DEPTH;
  localparam int NQ         = IN_ELS * OUT_ELS;
  // source number rides in the top payload bit
  localparam int SRC_BIT    = PAYLOAD_BITS - 1;
  localparam int PERIOD_NS  = 40;
  localparam int RAND_ROWS  = 40;
  localparam int ROWS       = 13 + RAND_ROWS;
  localparam int TIMEOUT_NS = PERIOD_NS * 40 * ROWS;
  localparam logic [IN_ELS-1:0] CREDIT_MASK = `XBAR_USE_CREDITS;

  logic                    clk_i;
  logic                    rst_n_i;
  logic [IN_ELS-1:0]       valid_i;
  flit_t [IN_ELS-1:0]      data_i;
  logic [IN_ELS-1:0]       credit_ready_o;
  logic [OUT_ELS-1:0]      valid_o;
  payload_t [OUT_ELS-1:0]  data_o;
  logic [OUT_ELS-1:0]      ready_i;

  // stimulus table with one word per row
  int                 tbl_phase   [ROWS];
  int                 tbl_src     [ROWS];
  int                 tbl_dest    [ROWS];
  payload_t           tbl_payload [ROWS];
  logic [OUT_ELS-1:0] tbl_ready   [ROWS];
  int                 n_rows;

  // rows waiting at each sender
  int pend_row [IN_ELS][ROWS];
  int pend_wr  [IN_ELS];
  int pend_rd  [IN_ELS];

  // expected payloads indexed by output * IN_ELS + source
  payload_t exp_mem [NQ][ROWS];
  int       exp_wr  [NQ];
  int       exp_rd  [NQ];

  int                 credits [IN_ELS];
  int                 pulses  [IN_ELS];
  int                 sent    [IN_ELS];
  int                 cur_phase;
  int                 seed = 39;
  logic [OUT_ELS-1:0] ready_pat;
  int                 bp_acc1;
  logic               bp_full_seen;
  logic               rr_next_src;
  logic [OUT_ELS-1:0] hold_v;
  payload_t           hold_data [OUT_ELS];

  tb_clk_gen #(
    .PERIOD_NS  (PERIOD_NS),
    .RST_CYCLES (8)
  ) i_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  xbar_router i_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .data_i         (data_i),
    .credit_ready_o (credit_ready_o),
    .valid_o        (valid_o),
    .data_o         (data_o),
    .ready_i        (ready_i)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("*** FAILED ***");
    $fatal(1, why);
  endtask

  task automatic add_row(input int phase, input int src, input int dest,
                         input logic [OUT_ELS-1:0] rdy);
    tbl_phase[n_rows]   = phase;
    tbl_src[n_rows]     = src;
    tbl_dest[n_rows]    = dest;
    tbl_ready[n_rows]   = rdy;
    // row number below the source bit keeps every word unique
    tbl_payload[n_rows] = payload_t'((src << SRC_BIT) | n_rows);
    n_rows++;
  endtask

  task automatic build_table();
    int                 src;
    int                 dest;
    logic [OUT_ELS-1:0] rdy;

    // single words sent one at a time
    add_row(1, 0, 0, 2'b11);
    add_row(1, 0, 1, 2'b11);
    add_row(1, 1, 0, 2'b11);
    add_row(1, 1, 1, 2'b11);
    // both queues fill toward output 0 while it is blocked
    add_row(2, 0, 0, 2'b10);
    add_row(2, 1, 0, 2'b10);
    add_row(2, 0, 0, 2'b10);
    add_row(2, 1, 0, 2'b10);
    // input 1 overfills against stalled output 0 while output 1 keeps moving
    add_row(3, 1, 0, 2'b10);
    add_row(3, 0, 1, 2'b10);
    add_row(3, 1, 0, 2'b10);
    add_row(3, 0, 1, 2'b10);
    add_row(3, 1, 0, 2'b10);
    for (int k = 0; k < RAND_ROWS; k++) begin
      src  = $unsigned($random(seed)) % IN_ELS;
      dest = $unsigned($random(seed)) % OUT_ELS;
      rdy  = OUT_ELS'($random(seed));
      add_row(4, src, dest, rdy);
    end
  endtask

  function automatic logic queues_empty();
    logic ok;

    ok = 1'b1;
    for (int q = 0; q < NQ; q++) begin
      ok = ok && (exp_rd[q] == exp_wr[q]);
    end
    return ok;
  endfunction

  // every sender is done or waiting on the DUT
  function automatic logic senders_settled();
    logic ok;

    ok = 1'b1;
    for (int i = 0; i < IN_ELS; i++) begin
      if (pend_rd[i] != pend_wr[i]) begin
        if (CREDIT_MASK[i]) begin
          ok = ok && (credits[i] == 0);
        end else begin
          ok = ok && !credit_ready_o[i];
        end
      end
    end
    return ok;
  endfunction

  function automatic logic router_idle();
    logic ok;

    ok = queues_empty();
    for (int i = 0; i < IN_ELS; i++) begin
      ok = ok && (pend_rd[i] == pend_wr[i]) && !valid_i[i];
    end
    return ok;
  endfunction

  task automatic start_phase(input int phase);
    cur_phase    = phase;
    rr_next_src  = 1'b0;
    bp_acc1      = 0;
    bp_full_seen = 1'b0;
  endtask

  // open all outputs once senders stall and wait for everything to leave
  task automatic drain();
    while (!senders_settled()) begin
      @(negedge clk_i);
    end
    ready_pat = '1;
    while (!router_idle()) begin
      @(negedge clk_i);
    end
    if (cur_phase == 3) begin
      check("credit_ready_o[1] full seen", bp_full_seen, 1'b1);
    end
  endtask

  // sender side obeying credit or ready rules per input
  always @(posedge clk_i) begin
    int   r;
    int   q;
    logic go;

    if (!rst_n_i) begin
      valid_i <= '0;
      ready_i <= '0;
    end else begin
      ready_i <= ready_pat;
      for (int i = 0; i < IN_ELS; i++) begin
        if (CREDIT_MASK[i] && credit_ready_o[i]) begin
          credits[i]++;
          pulses[i]++;
          check($sformatf("credits[%0d] bound", i), credits[i] <= DEPTH, 1'b1);
        end
        go = (pend_rd[i] != pend_wr[i]);
        if (CREDIT_MASK[i]) begin
          go = go && (credits[i] > 0);
        end else begin
          // a word strobed last cycle is not yet counted in the level
          go = go && credit_ready_o[i] && !valid_i[i];
        end
        if (cur_phase == 4 && ($random(seed) & 3) == 0) begin
          go = 1'b0;
        end
        if (go) begin
          r = pend_row[i][pend_rd[i]];
          q = tbl_dest[r] * IN_ELS + i;
          pend_rd[i]++;
          valid_i[i] <= 1'b1;
          data_i[i]  <= {tbl_payload[r], dest_id_t'(tbl_dest[r])};
          exp_mem[q][exp_wr[q]] = tbl_payload[r];
          exp_wr[q]++;
          sent[i]++;
          if (CREDIT_MASK[i]) begin
            credits[i]--;
          end
        end else begin
          valid_i[i] <= 1'b0;
        end
      end
    end
  end

  // output side scoreboard
  always @(posedge clk_i) begin
    int q;
    int src;

    if (rst_n_i) begin
      for (int o = 0; o < OUT_ELS; o++) begin
        if (cur_phase == 3 && valid_o[o]) begin
          if (hold_v[o]) begin
            check($sformatf("data_o[%0d] held", o), data_o[o], hold_data[o]);
          end
          hold_v[o]    = !ready_i[o];
          hold_data[o] = data_o[o];
        end else begin
          hold_v[o] = 1'b0;
        end
        if (valid_o[o] && ready_i[o]) begin
          src = data_o[o][SRC_BIT];
          q   = o * IN_ELS + src;
          if (exp_rd[q] == exp_wr[q]) begin
            abort_run($sformatf("output %0d delivered a word nobody sent", o));
          end
          check($sformatf("data_o[%0d]", o), data_o[o], exp_mem[q][exp_rd[q]]);
          exp_rd[q]++;
          if (cur_phase == 2 && o == 0) begin
            check("round robin source", src, rr_next_src);
            rr_next_src = !rr_next_src;
          end
        end
      end
      // level follows accepted words while output 0 cannot dequeue
      if (cur_phase == 3 && !ready_i[0]) begin
        check("credit_ready_o[1]", credit_ready_o[1], bp_acc1 < DEPTH);
        if (!credit_ready_o[1]) begin
          bp_full_seen = 1'b1;
        end
        bp_acc1 += valid_i[1];
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run("watchdog expired before all table rows completed");
  end

  initial begin
    int next_phase;

    valid_i   = '0;
    data_i    = '0;
    ready_i   = '0;
    ready_pat = '1;
    hold_v    = '0;
    n_rows    = 0;
    start_phase(0);
    for (int i = 0; i < IN_ELS; i++) begin
      pend_wr[i] = 0;
      pend_rd[i] = 0;
      credits[i] = DEPTH;
      pulses[i]  = 0;
      sent[i]    = 0;
    end
    for (int q = 0; q < NQ; q++) begin
      exp_wr[q] = 0;
      exp_rd[q] = 0;
    end
    build_table();

    wait (rst_n_i === 1'b1);
    @(negedge clk_i);
    check("valid_o", valid_o, 0);
    for (int i = 0; i < IN_ELS; i++) begin
      check($sformatf("credit_ready_o[%0d]", i), credit_ready_o[i], !CREDIT_MASK[i]);
    end

    for (int r = 0; r < n_rows; r++) begin
      if (tbl_phase[r] != cur_phase) begin
        start_phase(tbl_phase[r]);
      end
      ready_pat = tbl_ready[r];
      pend_row[tbl_src[r]][pend_wr[tbl_src[r]]] = r;
      pend_wr[tbl_src[r]]++;
      next_phase = (r + 1 < n_rows) ? tbl_phase[r + 1] : 0;
      if (next_phase != tbl_phase[r] || tbl_phase[r] == 1) begin
        drain();
      end
      @(negedge clk_i);
    end

    for (int i = 0; i < IN_ELS; i++) begin
      if (CREDIT_MASK[i]) begin
        check($sformatf("credit pulses[%0d]", i), pulses[i], sent[i]);
      end
    end
    if (queues_empty()) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "scoreboard not empty at end of run");
    end
  end

endmodule

// ==== verilog/xbar_arbiter.sv ====
// Router round-robin arbiter
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_arbiter
  import xbar_pkg::*;
  (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    xbar_req_if.arbiter                              req [`XBAR_IN_ELS],
    input  logic [`XBAR_OUT_ELS-1:0]                 ready_i,
    output logic [`XBAR_OUT_ELS-1:0]                 valid_o,
    output logic [`XBAR_OUT_ELS-1:0][`XBAR_IN_ELS-1:0] grants_o
  );

  localparam int IN_ELS   = `XBAR_IN_ELS;
  localparam int OUT_ELS  = `XBAR_OUT_ELS;
  localparam int PTR_BITS = (IN_ELS > 1) ? $clog2(IN_ELS) : 1;

  logic     [IN_ELS-1:0]   head_v;
  dest_id_t                head_dest [IN_ELS];
  logic     [IN_ELS-1:0]   yumi;

  // requests per output with one bit per input
  logic [OUT_ELS-1:0][IN_ELS-1:0] reqs;

  // priority pointer and current winner per output
  logic [PTR_BITS-1:0] ptr_q   [OUT_ELS];
  logic [PTR_BITS-1:0] win_idx [OUT_ELS];

  // head signals and yumi per input bundle
  for (genvar i = 0; i < IN_ELS; i++) begin : g_in
    assign head_v[i]    = req[i].head_v;
    assign head_dest[i] = req[i].head_dest;
    assign req[i].yumi  = yumi[i];
  end

  for (genvar o = 0; o < OUT_ELS; o++) begin : g_out
    for (genvar i = 0; i < IN_ELS; i++) begin : g_req
      assign reqs[o][i] = head_v[i] && (head_dest[i] == dest_id_t'(o));
    end

    // valid never looks at ready_i
    assign valid_o[o] = |reqs[o];
  end

  // scan from the pointer so the first requester wins
  always_comb begin
    int   idx;
    logic found;

    grants_o = '0;
    for (int o = 0; o < OUT_ELS; o++) begin
      found      = 1'b0;
      win_idx[o] = '0;
      for (int k = 0; k < IN_ELS; k++) begin
        idx = int'(ptr_q[o]) + k;
        if (idx >= IN_ELS) begin
          idx = idx - IN_ELS;
        end
        if (reqs[o][idx] && !found) begin
          found             = 1'b1;
          grants_o[o][idx]  = 1'b1;
          win_idx[o]        = PTR_BITS'(idx);
        end
      end
    end
  end

  // dequeue only when the granted output accepts
  always_comb begin
    for (int i = 0; i < IN_ELS; i++) begin
      yumi[i] = 1'b0;
      for (int o = 0; o < OUT_ELS; o++) begin
        yumi[i] = yumi[i] | (grants_o[o][i] & ready_i[o]);
      end
    end
  end

  // move past the winner after a transfer and hold under back-pressure
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < OUT_ELS; o++) begin
        ptr_q[o] <= '0;
      end
    end else begin
      for (int o = 0; o < OUT_ELS; o++) begin
        if (valid_o[o] && ready_i[o]) begin
          ptr_q[o] <= (win_idx[o] == PTR_BITS'(IN_ELS - 1)) ? '0 : win_idx[o] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/xbar_input_queue.sv ====
// Router input queue
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_input_queue
  import xbar_pkg::*;
  #(
    parameter flow_mode_e flow_mode = FLOW_READY
  )
  (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         valid_i,
    input  flit_t        data_i,
    output logic         credit_ready_o,
    xbar_req_if.queue    req
  );

  localparam int DEPTH     = `XBAR_FIFO_DEPTH;
  localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS  = $clog2(DEPTH + 1);

  // word storage
  flit_t mem_q [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;

  logic  full;
  logic  enq;
  logic  deq;
  flit_t head_flit;

  assign full = (count_q == CNT_BITS'(DEPTH));

  // full guard keeps the ring from overwriting the head
  assign enq  = valid_i && !full;
  assign deq  = req.yumi;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (deq) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // header decode on the head word
  assign head_flit     = mem_q[rd_ptr_q];
  assign req.head_v    = (count_q != '0);
  assign req.head_dest = head_flit[`XBAR_DEST_BITS-1:0];

  if (`XBAR_DROP_HEADER != 0) begin : g_drop
    assign req.head_payload = head_flit[`XBAR_WIDTH-1:`XBAR_DEST_BITS];
  end else begin : g_keep
    assign req.head_payload = head_flit;
  end

  // flow control back to the sender
  if (flow_mode == FLOW_CREDIT) begin : g_credit
    logic credit_q;

    // one pulse a cycle after each dequeue
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        credit_q <= 1'b0;
      end else begin
        credit_q <= deq;
      end
    end

    assign credit_ready_o = credit_q;
  end else begin : g_ready
    assign credit_ready_o = !full;
  end

endmodule

// ==== verilog/xbar_output_mux.sv ====
// Router output data select
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_output_mux
  import xbar_pkg::*;
  (
    xbar_req_if.mux                                   req [`XBAR_IN_ELS],
    input  logic [`XBAR_OUT_ELS-1:0][`XBAR_IN_ELS-1:0] grants_i,
    output payload_t [`XBAR_OUT_ELS-1:0]              data_o
  );

  localparam int IN_ELS  = `XBAR_IN_ELS;
  localparam int OUT_ELS = `XBAR_OUT_ELS;

  // payloads arrive already header-stripped from the queues
  payload_t [IN_ELS-1:0] payload;

  for (genvar i = 0; i < IN_ELS; i++) begin : g_in
    assign payload[i] = req[i].head_payload;
  end

  // and-or one-hot select giving zero with no grant
  always_comb begin
    for (int o = 0; o < OUT_ELS; o++) begin
      data_o[o] = '0;
      for (int i = 0; i < IN_ELS; i++) begin
        data_o[o] = data_o[o] | (payload[i] & {PAYLOAD_BITS{grants_i[o][i]}});
      end
    end
  end

endmodule

// ==== verilog/xbar_pkg.sv ====
// Router crossbar types
`include "xbar_settings.svh"

package xbar_pkg;

  // output word width after optional header strip
  localparam int PAYLOAD_BITS = (`XBAR_DROP_HEADER != 0) ?
                                (`XBAR_WIDTH - `XBAR_DEST_BITS) : `XBAR_WIDTH;

  // one input word with the dest id in the low bits
  typedef logic [`XBAR_WIDTH-1:0] flit_t;

  // destination output number
  typedef logic [`XBAR_DEST_BITS-1:0] dest_id_t;

  // word as it leaves an output
  typedef logic [PAYLOAD_BITS-1:0] payload_t;

  // how an input hands flow control back to its sender
  //   FLOW_READY  level while the queue has room
  //   FLOW_CREDIT one pulse per dequeued word
  typedef enum logic {
    FLOW_READY  = 1'b0,
    FLOW_CREDIT = 1'b1
  } flow_mode_e;

endpackage

// ==== verilog/xbar_req_if.sv ====
// Input queue request bundle
`timescale 1ns/1ps

// one instance per router input
// head word and request flow from the queue to the arbiter and mux
// while yumi flows back from the arbiter
interface xbar_req_if
  import xbar_pkg::*;
  ();

  // queue holds a word at its head
  logic     head_v;

  // decoded destination of the head word
  dest_id_t head_dest;

  // head word with the header already handled
  payload_t head_payload;

  // head word consumed at the next edge, only while head_v is high
  logic     yumi;

  modport queue (
    output head_v,
    output head_dest,
    output head_payload,
    input  yumi
  );

  modport arbiter (
    input  head_v,
    input  head_dest,
    output yumi
  );

  // data path only needs the payload
  modport mux (
    input  head_payload
  );

endinterface

// ==== verilog/xbar_router.sv ====
// Two by two packet router
`timescale 1ns/1ps
`include "xbar_settings.svh"

module xbar_router
  import xbar_pkg::*;
  (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // input side with the dest id in the low bits of each word
    input  logic [`XBAR_IN_ELS-1:0]           valid_i,
    input  flit_t [`XBAR_IN_ELS-1:0]          data_i,
    // credit pulse or ready level per input
    output logic [`XBAR_IN_ELS-1:0]           credit_ready_o,

    // valid/ready output side
    output logic [`XBAR_OUT_ELS-1:0]          valid_o,
    output payload_t [`XBAR_OUT_ELS-1:0]      data_o,
    input  logic [`XBAR_OUT_ELS-1:0]          ready_i
  );

  localparam int IN_ELS  = `XBAR_IN_ELS;
  localparam int OUT_ELS = `XBAR_OUT_ELS;

  // per-input flow mode select
  localparam logic [IN_ELS-1:0] USE_CREDITS = `XBAR_USE_CREDITS;

  // one request bundle per input queue
  xbar_req_if req_if [IN_ELS] ();

  logic [OUT_ELS-1:0][IN_ELS-1:0] grants;

  // decode stage
  for (genvar i = 0; i < IN_ELS; i++) begin : g_queue
    xbar_input_queue #(
      .flow_mode (USE_CREDITS[i] ? FLOW_CREDIT : FLOW_READY)
    ) i_queue (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .valid_i        (valid_i[i]),
      .data_i         (data_i[i]),
      .credit_ready_o (credit_ready_o[i]),
      .req            (req_if[i])
    );
  end

  // execute stage
  xbar_arbiter i_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req      (req_if),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .grants_o (grants)
  );

  // result stage
  xbar_output_mux i_output_mux (
    .req      (req_if),
    .grants_i (grants),
    .data_o   (data_o)
  );

endmodule

// ==== verilog/xbar_settings.svh ====
// Router crossbar build settings
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// port counts
`define XBAR_IN_ELS 2
`define XBAR_OUT_ELS 2

// dest id width of at least one bit
`define XBAR_DEST_BITS (($clog2(`XBAR_OUT_ELS) > 0) ? $clog2(`XBAR_OUT_ELS) : 1)

// full input word with the header included
`define XBAR_WIDTH 16

// 1 strips the dest bits from the output word
`define XBAR_DROP_HEADER 1

// words per input queue
`define XBAR_FIFO_DEPTH 2

// bit i set means input i returns credit pulses instead of ready
`define XBAR_USE_CREDITS 2'b01

`endif
